/* dv/uart_props.sv */
`timescale 1ns/100ps

module uart_props
    import uart_pkg::*;
(
    input logic    clk_i,
    input logic    arst_n_i,
    input wb_req_t req_i,
    input wb_rsp_t rsp_i,
    input logic    txd_i,
    input logic    irq_i,
    input logic    rx_empty_i
);

    logic req;

    assign req = req_i.cyc && req_i.stb;

    a_ack_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_i.ack |=> !rsp_i.ack)
        else $error("Wishbone ack stayed high for more than one cycle");

    // A fresh request gets its ack on the next edge
    a_ack_follows_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        req && !rsp_i.ack |=> rsp_i.ack)
        else $error("Wishbone request was not acknowledged one cycle later");

    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rsp_i.ack |-> $past(req))
        else $error("Wishbone ack without a request in the previous cycle");

    a_irq_tracks_fifo: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        irq_i == !rx_empty_i)
        else $error("irq_o does not match the receive FIFO holding data");

    a_txd_idle_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |=> txd_i)
        else $error("txd_o not high in the cycle after reset release");

endmodule

bind uart_top uart_props props_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (wb_req_i),
    .rsp_i      (wb_rsp_o),
    .txd_i      (txd_o),
    .irq_i      (irq_o),
    .rx_empty_i (rx_empty)
);

/* dv/uart_tb.sv */
`timescale 1ns/100ps

module uart_tb
    import uart_pkg::*;
();

    localparam int   ACK_TIMEOUT  = 8;
    localparam int   LINE_TIMEOUT = 5000;
    localparam int   POLL_TIMEOUT = 200;
    localparam int   FAST_DIV     = 8;
    localparam int   SLOW_DIV     = 200;
    localparam logic LINE_LOOP    = 1'b0;
    localparam logic LINE_DRIVE   = 1'b1;

    logic        clk;
    logic        arst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        rxd;
    logic        txd;
    logic        irq;
    logic        line_sel;
    logic        drv_line;
    int          div;
    int          errors;
    int          checks;
    logic [31:0] rng;
    logic [7:0]  sent [$];

    // Receive line comes from the transmitter or from the serial driver
    assign rxd = (line_sel == LINE_LOOP) ? txd : drv_line;

    uart_top uart_top_i (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .rxd_i    (rxd),
        .txd_o    (txd),
        .irq_o    (irq)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] cfg_word(input int d, input logic pen,
                                             input logic podd, input logic two);
        return {d[15:0], pen, podd, two, 13'b0};
    endfunction

    function automatic logic [31:0] status_word(input logic rx_valid, input logic rx_full,
                                                input logic tx_empty, input logic tx_full,
                                                input logic ovr, input logic ferr,
                                                input logic perr);
        return {25'b0, perr, ferr, ovr, tx_full, tx_empty, rx_full, rx_valid};
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0] sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    task automatic report_counts();
        $display("Checks: %0d, errors: %0d", checks, errors);
    endtask

    task automatic abort_run(input string what);
        $display("Timed out waiting for %s at %0t", what, $time);
        report_counts();
        $display("Verification failed");
        $finish;
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // Entered and left just after a falling edge
    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                              input logic [3:0] sel, output logic [31:0] rdat);
        int n;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.sel = sel;
        wb_req.dat = wdat;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (wb_rsp.ack !== 1'b1 && n < ACK_TIMEOUT);
        if (wb_rsp.ack !== 1'b1) begin
            abort_run("Wishbone ack");
        end
        rdat = wb_rsp.dat;
        // Hold through the ack edge so the access takes effect
        @(negedge clk);
        wb_req = '0;
        @(negedge clk);
    endtask

    task automatic bus_write(input logic [3:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel);
        logic [31:0] unused;
        bus_access(1'b1, adr, dat, sel, unused);
    endtask

    task automatic bus_read(input logic [3:0] adr, output logic [31:0] dat);
        bus_access(1'b0, adr, 32'h0, 4'hf, dat);
    endtask

    task automatic set_config(input int d, input logic pen, input logic podd, input logic two);
        div = d;
        bus_write(ADDR_CONFIG, cfg_word(d, pen, podd, two), 4'hf);
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (irq !== 1'b1 && n < LINE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (irq !== 1'b1) begin
            abort_run("irq_o after a received frame");
        end
    endtask

    task automatic wait_rx_valid();
        logic [31:0] st;
        int n;
        st = '0;
        n = 0;
        while (st[0] !== 1'b1 && n < POLL_TIMEOUT) begin
            bus_read(ADDR_STATUS, st);
            n++;
        end
        if (st[0] !== 1'b1) begin
            abort_run("STATUS rx_valid");
        end
    endtask

    task automatic drive_bit(input logic b);
        drv_line = b;
        repeat (div) @(negedge clk);
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic pen, input logic podd,
                               input logic two, input logic bad_stop, input logic bad_par);
        logic par;
        int i;
        par = podd ^ (^data);
        line_sel = LINE_DRIVE;
        drive_bit(1'b0);
        for (i = 0; i < 8; i++) begin
            drive_bit(data[i]);
        end
        if (pen) begin
            drive_bit(par ^ bad_par);
        end
        drive_bit(!bad_stop);
        if (two) begin
            drive_bit(1'b1);
        end
        drive_bit(1'b1);
    endtask

    // Samples txd at mid-bit, counted from the first low edge seen
    task automatic check_tx_frame(input logic [7:0] data, input logic pen, input logic podd,
                                  input logic two);
        logic par;
        int n;
        int i;
        par = podd ^ (^data);
        n = 0;
        while (txd !== 1'b0 && n < LINE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (txd !== 1'b0) begin
            abort_run("a start bit on txd_o");
        end
        repeat (div / 2) @(negedge clk);
        check_bit("txd_o start bit", txd, 1'b0);
        for (i = 0; i < 8; i++) begin
            repeat (div) @(negedge clk);
            check_bit($sformatf("txd_o data bit %0d", i), txd, data[i]);
        end
        if (pen) begin
            repeat (div) @(negedge clk);
            check_bit("txd_o parity bit", txd, par);
        end
        repeat (div) @(negedge clk);
        check_bit("txd_o stop bit", txd, 1'b1);
        if (two) begin
            repeat (div) @(negedge clk);
            check_bit("txd_o second stop bit", txd, 1'b1);
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] model;
        logic [31:0] r;
        logic [31:0] wd;
        logic [7:0]  b;
        logic        pen;
        logic        podd;
        logic        two;
        int          i;
        clk      = 1'b0;
        arst_n   = 1'b0;
        wb_req   = '0;
        line_sel = LINE_DRIVE;
        drv_line = 1'b1;
        div      = DIV_RESET;
        errors   = 0;
        checks   = 0;
        rng      = 32'hbb97;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_bit("txd_o after reset", txd, 1'b1);
        check_bit("irq_o after reset", irq, 1'b0);

        // CONFIG reset value and byte lanes
        model = cfg_word(DIV_RESET, 1'b0, 1'b0, 1'b0);
        bus_read(ADDR_CONFIG, rd);
        check_word("CONFIG", rd, model);
        for (i = 0; i < 6; i++) begin
            draw_random(r);
            draw_random(wd);
            bus_write(ADDR_CONFIG, wd, r[3:0]);
            model = lane_merge(model, wd, r[3:0]);
            bus_read(ADDR_CONFIG, rd);
            check_word("CONFIG", rd, model);
        end
        bus_write(ADDR_STATUS, 32'hffff_ffff, 4'hf);
        bus_read(ADDR_STATUS, rd);
        check_word("STATUS", rd, status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        bus_read(ADDR_TXDATA, rd);
        check_word("TXDATA read", rd, 32'h0);

        // Frame shape under four line formats
        for (i = 0; i < 4; i++) begin
            pen  = (i != 0);
            podd = (i >= 2);
            two  = (i == 3);
            set_config(FAST_DIV, pen, podd, two);
            draw_random(r);
            draw_random(wd);
            bus_write(ADDR_TXDATA, {24'b0, r[7:0]}, 4'b0001);
            // Second byte waits behind the first, so a short stop shows as an early start
            fork
                check_tx_frame(r[7:0], pen, podd, two);
                bus_write(ADDR_TXDATA, {24'b0, wd[7:0]}, 4'b0001);
            join
            check_tx_frame(wd[7:0], pen, podd, two);
        end

        // Loopback of ten bytes
        set_config(FAST_DIV, 1'b1, 1'b0, 1'b0);
        line_sel = LINE_LOOP;
        for (i = 0; i < 10; i++) begin
            draw_random(r);
            sent.push_back(r[7:0]);
            bus_write(ADDR_TXDATA, {24'b0, r[7:0]}, 4'b0001);
        end
        for (i = 0; i < 10; i++) begin
            wait_rx_valid();
            check_bit("irq_o", irq, 1'b1);
            b = sent.pop_front();
            bus_read(ADDR_RXDATA, rd);
            check_word("RXDATA", rd, {23'b0, 1'b1, b});
        end
        check_bit("irq_o", irq, 1'b0);
        bus_read(ADDR_RXDATA, rd);
        check_word("RXDATA when empty", rd, 32'h0);
        bus_read(ADDR_STATUS, rd);
        check_word("STATUS", rd, status_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));

        // Framing and parity errors
        set_config(FAST_DIV, 1'b1, 1'b0, 1'b0);
        draw_random(r);
        drive_frame(r[7:0], 1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_irq();
        bus_read(ADDR_RXDATA, rd);
        check_word("RXDATA", rd, {23'b0, 1'b1, r[7:0]});
        draw_random(wd);
        drive_frame(wd[7:0], 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        wait_irq();
        bus_read(ADDR_STATUS, rd);
        check_word("STATUS", rd, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
        bus_read(ADDR_STATUS, rd);
        check_word("STATUS", rd, status_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0));
        bus_read(ADDR_RXDATA, rd);
        check_word("RXDATA", rd, {23'b0, 1'b1, wd[7:0]});

        // Receive FIFO overrun
        set_config(FAST_DIV, 1'b0, 1'b0, 1'b0);
        for (i = 0; i < 17; i++) begin
            draw_random(r);
            sent.push_back(r[7:0]);
            drive_frame(r[7:0], 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        bus_read(ADDR_STATUS, rd);
        check_word("STATUS", rd, status_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
        for (i = 0; i < 16; i++) begin
            b = sent.pop_front();
            bus_read(ADDR_RXDATA, rd);
            check_word("RXDATA", rd, {23'b0, 1'b1, b});
        end
        bus_read(ADDR_RXDATA, rd);
        check_word("RXDATA after 16 reads", rd, 32'h0);
        sent.delete();

        // Transmit FIFO fills faster than a slow line drains it
        set_config(SLOW_DIV, 1'b0, 1'b0, 1'b0);
        for (i = 0; i < 20; i++) begin
            draw_random(r);
            bus_write(ADDR_TXDATA, {24'b0, r[7:0]}, 4'b0001);
        end
        bus_read(ADDR_STATUS, rd);
        check_word("STATUS", rd, status_word(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

        report_counts();
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* rtl/uart_fifo.sv */
`timescale 1ns/100ps

module uart_fifo
    import uart_pkg::*;
(
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             push_i,
    input  logic [7:0]       wdata_i,
    input  logic             pop_i,
    output logic [7:0]       rdata_o,
    output logic             empty_o,
    output logic             full_o,
    output logic [FIFO_AW:0] count_o
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign empty_o = (count_o == '0);
    assign full_o  = (count_o == (FIFO_AW+1)'(FIFO_DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head is always visible
    assign rdata_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
        end
    end

endmodule

/* rtl/uart_pkg.sv */
package uart_pkg;

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;
    localparam int DIV_W      = 16;
    localparam int DIV_RESET  = 434;

    // Word addresses
    localparam logic [3:0] ADDR_CONFIG = 4'd0;
    localparam logic [3:0] ADDR_STATUS = 4'd1;
    localparam logic [3:0] ADDR_RXDATA = 4'd2;
    localparam logic [3:0] ADDR_TXDATA = 4'd3;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [3:0]  sel;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Divisor sits in the upper half of the config word
    typedef struct packed {
        logic [DIV_W-1:0] divisor;
        logic             parity_en;
        logic             parity_odd;
        logic             two_stop;
        logic [12:0]      reserved;
    } uart_cfg_t;

    typedef union packed {
        logic [31:0] raw;
        uart_cfg_t   fields;
    } uart_cfg_u;

    // rx_valid is bit 0
    typedef struct packed {
        logic [24:0] pad;
        logic        parity_err;
        logic        frame_err;
        logic        rx_overrun;
        logic        tx_full;
        logic        tx_empty;
        logic        rx_full;
        logic        rx_valid;
    } uart_status_t;

    typedef struct packed {
        logic frame_err;
        logic parity_err;
    } rx_err_t;

endpackage

/* rtl/uart_regs.sv */
`timescale 1ns/100ps

module uart_regs
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  wb_req_t    wb_req_i,
    output wb_rsp_t    wb_rsp_o,
    output uart_cfg_t  cfg_o,
    output logic       tx_push_o,
    output logic [7:0] tx_data_o,
    input  logic       tx_full_i,
    input  logic       tx_empty_i,
    output logic       rx_pop_o,
    input  logic [7:0] rx_data_i,
    input  logic       rx_empty_i,
    input  logic       rx_full_i,
    input  logic       rx_valid_i,
    input  rx_err_t    rx_err_i,
    output logic       irq_o
);

    uart_cfg_u    cfg_q;
    uart_status_t status;
    logic         req;
    logic         ack_q;
    logic         wr_acc;
    logic         rd_acc;
    logic         overrun_q;
    rx_err_t      err_q;
    logic [31:0]  rd_data;

    assign req    = wb_req_i.cyc && wb_req_i.stb;
    // Side effects happen in the ack cycle, while the request is still held
    assign wr_acc = ack_q && req && wb_req_i.we;
    assign rd_acc = ack_q && req && !wb_req_i.we;

    assign status = '{
        pad:        '0,
        parity_err: err_q.parity_err,
        frame_err:  err_q.frame_err,
        rx_overrun: overrun_q,
        tx_full:    tx_full_i,
        tx_empty:   tx_empty_i,
        rx_full:    rx_full_i,
        rx_valid:   !rx_empty_i
    };

    always_comb begin
        case (wb_req_i.adr)
            ADDR_CONFIG: rd_data = cfg_q.raw;
            ADDR_STATUS: rd_data = status;
            ADDR_RXDATA: rd_data = rx_empty_i ? '0 : {23'b0, 1'b1, rx_data_i};
            default:     rd_data = '0;
        endcase
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_acc ? rd_data : '0;

    assign cfg_o     = cfg_q.fields;
    assign tx_push_o = wr_acc && wb_req_i.adr == ADDR_TXDATA && wb_req_i.sel[0];
    assign tx_data_o = wb_req_i.dat[7:0];
    assign rx_pop_o  = rd_acc && wb_req_i.adr == ADDR_RXDATA && !rx_empty_i;
    assign irq_o     = !rx_empty_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q     <= 1'b0;
            cfg_q     <= '{fields: '{divisor: DIV_W'(DIV_RESET), default: '0}};
            overrun_q <= 1'b0;
            err_q     <= '0;
        end else begin
            ack_q <= req && !ack_q;
            if (wr_acc && wb_req_i.adr == ADDR_CONFIG) begin
                for (int i = 0; i < 4; i++) begin
                    if (wb_req_i.sel[i]) begin
                        cfg_q.raw[8*i +: 8] <= wb_req_i.dat[8*i +: 8];
                    end
                end
            end
            // New errors win over a clearing STATUS read
            if (rd_acc && wb_req_i.adr == ADDR_STATUS) begin
                overrun_q <= rx_valid_i && rx_full_i;
                err_q     <= rx_valid_i ? rx_err_i : '0;
            end else if (rx_valid_i) begin
                overrun_q <= overrun_q || rx_full_i;
                err_q     <= err_q | rx_err_i;
            end
        end
    end

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  uart_cfg_t cfg_i,
    input  logic      rxd_i,
    output logic      valid_o,
    output logic [7:0] data_o,
    output rx_err_t   err_o
);

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_e;

    rx_state_e        state;
    logic [1:0]       sync;
    logic             rxd_prev;
    logic             rxd_s;
    logic             fall;
    logic [DIV_W-1:0] cnt;
    logic [DIV_W-1:0] half_bit;
    logic             sample;
    logic [2:0]       bit_idx;
    logic             last_stop;
    uart_cfg_t        cfg_q;
    logic [7:0]       shift;
    logic             par;
    logic             par_bad;

    assign rxd_s     = sync[1];
    assign fall      = rxd_prev && !rxd_s;
    assign half_bit  = (cfg_q.divisor >> 1) - 1'b1;
    assign sample    = (cnt == cfg_q.divisor - 1'b1);
    assign last_stop = !cfg_q.two_stop || bit_idx[0];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync     <= 2'b11;
            rxd_prev <= 1'b1;
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            valid_o  <= 1'b0;
        end else begin
            sync     <= {sync[0], rxd_i};
            rxd_prev <= rxd_s;
            valid_o  <= 1'b0;
            cnt      <= cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Line back high at mid start bit means a glitch
                    if (cnt == half_bit) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (sample) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= cfg_q.parity_en ? RX_PARITY : RX_STOP;
                        end
                    end
                end
                RX_PARITY: begin
                    if (sample) begin
                        cnt   <= '0;
                        state <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (sample) begin
                        cnt <= '0;
                        if (last_stop) begin
                            bit_idx <= '0;
                            valid_o <= 1'b1;
                            state   <= RX_IDLE;
                        end else begin
                            bit_idx <= 3'd1;
                        end
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == RX_IDLE && fall) begin
            cfg_q   <= cfg_i;
            par     <= cfg_i.parity_odd;
            par_bad <= 1'b0;
        end
        if (state == RX_DATA && sample) begin
            shift <= {rxd_s, shift[7:1]};
            par   <= par ^ rxd_s;
        end
        if (state == RX_PARITY && sample) begin
            par_bad <= (par != rxd_s);
        end
        if (state == RX_STOP && sample && last_stop) begin
            data_o           <= shift;
            err_o.frame_err  <= !rxd_s;
            err_o.parity_err <= par_bad;
        end
    end

endmodule

/* rtl/uart_top.sv */
`timescale 1ns/100ps

module uart_top
    import uart_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o,
    input  logic    rxd_i,
    output logic    txd_o,
    output logic    irq_o
);

    uart_cfg_t  cfg;
    rx_err_t    rx_err;
    logic [7:0] tx_wdata;
    logic [7:0] tx_rdata;
    logic [7:0] rx_wdata;
    logic [7:0] rx_rdata;
    logic       tx_push;
    logic       tx_pop;
    logic       tx_empty;
    logic       tx_full;
    logic       rx_push;
    logic       rx_pop;
    logic       rx_empty;
    logic       rx_full;

    uart_regs regs_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wb_req_i   (wb_req_i),
        .wb_rsp_o   (wb_rsp_o),
        .cfg_o      (cfg),
        .tx_push_o  (tx_push),
        .tx_data_o  (tx_wdata),
        .tx_full_i  (tx_full),
        .tx_empty_i (tx_empty),
        .rx_pop_o   (rx_pop),
        .rx_data_i  (rx_rdata),
        .rx_empty_i (rx_empty),
        .rx_full_i  (rx_full),
        .rx_valid_i (rx_push),
        .rx_err_i   (rx_err),
        .irq_o      (irq_o)
    );

    // Transmit path
    uart_fifo tx_fifo_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .push_i   (tx_push),
        .wdata_i  (tx_wdata),
        .pop_i    (tx_pop),
        .rdata_o  (tx_rdata),
        .empty_o  (tx_empty),
        .full_o   (tx_full),
        .count_o  ()
    );

    uart_tx tx_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cfg_i    (cfg),
        .empty_i  (tx_empty),
        .data_i   (tx_rdata),
        .pop_o    (tx_pop),
        .txd_o    (txd_o)
    );

    // Receive path
    uart_rx rx_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cfg_i    (cfg),
        .rxd_i    (rxd_i),
        .valid_o  (rx_push),
        .data_o   (rx_wdata),
        .err_o    (rx_err)
    );

    uart_fifo rx_fifo_i (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .push_i   (rx_push),
        .wdata_i  (rx_wdata),
        .pop_i    (rx_pop),
        .rdata_o  (rx_rdata),
        .empty_o  (rx_empty),
        .full_o   (rx_full),
        .count_o  ()
    );

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  uart_cfg_t  cfg_i,
    input  logic       empty_i,
    input  logic [7:0] data_i,
    output logic       pop_o,
    output logic       txd_o
);

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_e;

    tx_state_e        state;
    logic [DIV_W-1:0] cnt;
    logic             bit_end;
    logic [2:0]       bit_idx;
    logic             shift_now;
    uart_cfg_t        cfg_q;
    logic [7:0]       shift;
    logic             parity;

    // Frame starts as soon as a byte is waiting
    assign pop_o     = (state == TX_IDLE) && !empty_i;
    assign bit_end   = (cnt == cfg_q.divisor - 1'b1);
    assign shift_now = bit_end && (state == TX_START ||
                                   (state == TX_DATA && bit_idx != 3'd7));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd_o   <= 1'b1;
        end else begin
            cnt <= (state == TX_IDLE || bit_end) ? '0 : cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    if (pop_o) begin
                        txd_o <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        txd_o <= shift[0];
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            txd_o <= cfg_q.parity_en ? parity : 1'b1;
                            state <= cfg_q.parity_en ? TX_PARITY : TX_STOP;
                        end else begin
                            txd_o <= shift[0];
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) begin
                        txd_o <= 1'b1;
                        state <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        if (cfg_q.two_stop && !bit_idx[0]) begin
                            bit_idx <= 3'd1;
                        end else begin
                            bit_idx <= '0;
                            state   <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Odd parity seeds the accumulator with one
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            cfg_q  <= cfg_i;
            shift  <= data_i;
            parity <= cfg_i.parity_odd;
        end else if (shift_now) begin
            shift  <= shift >> 1;
            parity <= parity ^ shift[0];
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module uart_tb \
    -Mdir obj_dir -o uart_sim
if [ $? -ne 0 ]; then
    echo "run.sh: build failed"
    exit 1
fi

./obj_dir/uart_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulator exited with status $sim_status"
    exit 1
fi

if grep -qx "Verification passed" sim.log; then
    exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1

/* tb.f */
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
dv/uart_props.sv
dv/uart_tb.sv
